//--- verilog/fetch_pkg.sv
package fetch_pkg;

    // first fetch address after reset.
    localparam logic [31:0] reset_pc = 32'h8000_0000;

    // cache line geometry.
    localparam int line_words  = 4;
    localparam int line_bits   = line_words * 32;
    localparam int offset_bits = 4;                 // byte offset in a line.
    localparam int index_bits  = 4;                 // 16 sets.
    localparam int tag_bits    = 32 - index_bits - offset_bits;

    // sdram window, a000_0000 to bfff_ffff, takes bursts.
    localparam logic [3:0] sdram_hi_a = 4'hA;
    localparam logic [3:0] sdram_hi_b = 4'hB;

    // axi4 encodings.
    localparam logic [1:0] burst_fixed = 2'b00;
    localparam logic [1:0] burst_incr  = 2'b01;
    localparam logic [2:0] size_word   = 3'b010;    // 4 bytes per beat.
    localparam logic [1:0] resp_okay   = 2'b00;

endpackage

//--- verilog/icache.sv
`timescale 1ns/1ps

module icache
    import fetch_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,

    input  logic [31:0]          lookup_pc,
    output logic                 hit,
    output logic [31:0]          hit_inst,

    input  logic                 fill_valid,
    input  logic [31:0]          fill_addr,
    input  logic [line_bits-1:0] fill_line
);

    logic [tag_bits-1:0]          tag_q  [1 << index_bits];
    logic [line_bits-1:0]         data_q [1 << index_bits];
    logic [(1 << index_bits)-1:0] valid_q;

    logic [index_bits-1:0]    rd_index;
    logic [tag_bits-1:0]      rd_tag;
    logic [offset_bits-3:0]   rd_word;
    logic [line_bits-1:0]     rd_line;
    logic [index_bits-1:0]    wr_index;
    logic [tag_bits-1:0]      wr_tag;

    assign rd_index = lookup_pc[offset_bits +: index_bits];
    assign rd_tag   = lookup_pc[31 -: tag_bits];
    assign rd_word  = lookup_pc[offset_bits-1:2];

    assign wr_index = fill_addr[offset_bits +: index_bits];
    assign wr_tag   = fill_addr[31 -: tag_bits];

    // lookup is purely combinational.
    assign rd_line  = data_q[rd_index];
    assign hit      = valid_q[rd_index] && (tag_q[rd_index] == rd_tag);
    assign hit_inst = rd_line[rd_word*32 +: 32];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
        end else if (fill_valid) begin
            valid_q[wr_index] <= 1'b1;
        end
    end

    // tag and line follow the valid bit.
    always_ff @(posedge clk) begin
        if (fill_valid) begin
            tag_q[wr_index]  <= wr_tag;
            data_q[wr_index] <= fill_line;
        end
    end

endmodule

//--- verilog/refill_ctrl.sv
`timescale 1ns/1ps

module refill_ctrl
    import fetch_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,

    input  logic                 refill_req,
    input  logic [31:0]          refill_addr,
    output logic                 refill_done,
    output logic                 refill_fault,
    output logic [line_bits-1:0] refill_line,

    output logic                 fill_valid,
    output logic [31:0]          fill_addr,
    output logic [line_bits-1:0] fill_line,

    output logic                 arvalid,
    input  logic                 arready,
    output logic [31:0]          araddr,
    output logic [3:0]           arid,
    output logic [7:0]           arlen,
    output logic [2:0]           arsize,
    output logic [1:0]           arburst,
    input  logic                 rvalid,
    output logic                 rready,
    input  logic [31:0]          rdata,
    input  logic [1:0]           rresp,
    input  logic                 rlast,
    input  logic [3:0]           rid
);

    typedef enum logic [1:0] {
        st_idle,
        st_ar,
        st_r
    } state_t;

    state_t                        state_q;
    logic [31:0]                   base_q;
    logic                          burst_q;
    logic [$clog2(line_words)-1:0] beat_q;
    logic                          fault_q;
    logic [line_bits-1:0]          line_q;

    logic req_sdram;
    logic beat_take;
    logic beat_err;
    logic beat_last;

    assign req_sdram = (refill_addr[31:28] == sdram_hi_a) || (refill_addr[31:28] == sdram_hi_b);

    assign beat_take = (state_q == st_r) && rvalid && rready;
    assign beat_err  = (rresp != resp_okay) || (rid != arid); // stray id counts as a fault.
    // bursts end on rlast, single reads on the beat count.
    assign beat_last = burst_q ? rlast : (int'(beat_q) == line_words - 1);

    assign arid   = 4'd0;
    assign arsize = size_word;

    assign refill_fault = fault_q;
    assign refill_line  = line_q;
    assign fill_addr    = base_q;
    assign fill_line    = line_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q     <= st_idle;
            arvalid     <= 1'b0;
            rready      <= 1'b0;
            refill_done <= 1'b0;
            fill_valid  <= 1'b0;
            beat_q      <= '0;
            fault_q     <= 1'b0;
        end else begin
            refill_done <= 1'b0;
            fill_valid  <= 1'b0;
            case (state_q)
                st_idle: begin
                    if (refill_req) begin
                        arvalid <= 1'b1;
                        beat_q  <= '0;
                        fault_q <= 1'b0;
                        state_q <= st_ar;
                    end
                end
                st_ar: begin
                    if (arready) begin
                        arvalid <= 1'b0;
                        rready  <= 1'b1;
                        state_q <= st_r;
                    end
                end
                st_r: begin
                    if (beat_take) begin
                        beat_q  <= beat_q + 1'b1;
                        fault_q <= fault_q | beat_err;
                        rready  <= 1'b0;
                        if (beat_last) begin
                            refill_done <= 1'b1;
                            fill_valid  <= !(fault_q | beat_err); // faulted lines stay out.
                            state_q     <= st_idle;
                        end else if (!burst_q) begin
                            arvalid <= 1'b1; // next single-beat read.
                            state_q <= st_ar;
                        end else begin
                            rready <= 1'b1;
                        end
                    end
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    // address fields and collected beats.
    always_ff @(posedge clk) begin
        if (state_q == st_idle && refill_req) begin
            base_q  <= refill_addr;
            burst_q <= req_sdram;
            araddr  <= refill_addr;
            arlen   <= req_sdram ? 8'(line_words - 1) : 8'd0;
            arburst <= req_sdram ? burst_incr : burst_fixed;
        end else if (beat_take && !beat_last && !burst_q) begin
            araddr <= araddr + 32'd4;
        end
        if (beat_take) begin
            line_q[beat_q*32 +: 32] <= rdata;
        end
    end

endmodule

//--- verilog/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit
    import fetch_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,

    output logic                 inst_valid,
    input  logic                 inst_ready,
    output logic [31:0]          inst_pc,
    output logic [31:0]          inst_data,
    output logic                 inst_fault,

    input  logic                 redirect_valid,
    input  logic [31:0]          redirect_pc,

    output logic [31:0]          lookup_pc,
    input  logic                 hit,
    input  logic [31:0]          hit_inst,

    output logic                 refill_req,
    output logic [31:0]          refill_addr,
    input  logic                 refill_done,
    input  logic                 refill_fault,
    input  logic [line_bits-1:0] refill_line
);

    typedef enum logic [1:0] {
        st_lookup,
        st_miss,
        st_deliver
    } state_t;

    state_t      state_q;
    logic [31:0] pc_q;
    logic        discard_q; // redirected while the refill was in flight.

    logic                   can_load;
    logic                   take_hit;
    logic                   start_miss;
    logic                   miss_done;
    logic                   pc_en;
    logic [31:0]            pc_d;
    logic [offset_bits-3:0] word_sel;
    logic [31:0]            miss_word;

    assign can_load   = !inst_valid || inst_ready;
    assign take_hit   = (state_q == st_lookup) && can_load && hit && !redirect_valid;
    assign start_miss = (state_q == st_lookup) && can_load && !hit && !redirect_valid;
    assign miss_done  = (state_q == st_miss) && refill_done && !redirect_valid && !discard_q;

    assign pc_en = redirect_valid || take_hit || miss_done;
    assign pc_d  = redirect_valid ? redirect_pc : pc_q + 32'd4;

    assign word_sel  = pc_q[offset_bits-1:2];
    assign miss_word = refill_line[word_sel*32 +: 32];
    assign lookup_pc = pc_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q    <= st_lookup;
            pc_q       <= reset_pc;
            discard_q  <= 1'b0;
            inst_valid <= 1'b0;
            refill_req <= 1'b0;
        end else begin
            refill_req <= start_miss;
            if (pc_en) begin
                pc_q <= pc_d;
            end
            // redirect drops whatever is held.
            if (redirect_valid) begin
                inst_valid <= 1'b0;
            end else if (take_hit || miss_done) begin
                inst_valid <= 1'b1;
            end else if (inst_ready) begin
                inst_valid <= 1'b0;
            end
            case (state_q)
                st_lookup: begin
                    if (start_miss) begin
                        state_q <= st_miss;
                    end
                end
                st_miss: begin
                    if (refill_done) begin
                        discard_q <= 1'b0;
                        state_q   <= miss_done ? st_deliver : st_lookup;
                    end else if (redirect_valid) begin
                        discard_q <= 1'b1;
                    end
                end
                st_deliver: begin
                    if (redirect_valid || inst_ready) begin
                        state_q <= st_lookup;
                    end
                end
                default: state_q <= st_lookup;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start_miss) begin
            refill_addr <= {pc_q[31:offset_bits], {offset_bits{1'b0}}};
        end
        if (take_hit) begin
            inst_pc    <= pc_q;
            inst_data  <= hit_inst;
            inst_fault <= 1'b0;
        end else if (miss_done) begin
            inst_pc    <= pc_q;
            inst_data  <= refill_fault ? 32'd0 : miss_word;
            inst_fault <= refill_fault;
        end
    end

endmodule

//--- verilog/fetch_top.sv
`timescale 1ns/1ps

module fetch_top
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    output logic        inst_valid,
    input  logic        inst_ready,
    output logic [31:0] inst_pc,
    output logic [31:0] inst_data,
    output logic        inst_fault,

    input  logic        redirect_valid,
    input  logic [31:0] redirect_pc,

    output logic        arvalid,
    input  logic        arready,
    output logic [31:0] araddr,
    output logic [3:0]  arid,
    output logic [7:0]  arlen,
    output logic [2:0]  arsize,
    output logic [1:0]  arburst,
    input  logic        rvalid,
    output logic        rready,
    input  logic [31:0] rdata,
    input  logic [1:0]  rresp,
    input  logic        rlast,
    input  logic [3:0]  rid
);

    logic [31:0]          lookup_pc;
    logic                 hit;
    logic [31:0]          hit_inst;
    logic                 refill_req;
    logic [31:0]          refill_addr;
    logic                 refill_done;
    logic                 refill_fault;
    logic [line_bits-1:0] refill_line;
    logic                 fill_valid;
    logic [31:0]          fill_addr;
    logic [line_bits-1:0] fill_line;

    fetch_unit i_fetch_unit (
        .clk            (clk),
        .rst            (rst),
        .inst_valid     (inst_valid),
        .inst_ready     (inst_ready),
        .inst_pc        (inst_pc),
        .inst_data      (inst_data),
        .inst_fault     (inst_fault),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .lookup_pc      (lookup_pc),
        .hit            (hit),
        .hit_inst       (hit_inst),
        .refill_req     (refill_req),
        .refill_addr    (refill_addr),
        .refill_done    (refill_done),
        .refill_fault   (refill_fault),
        .refill_line    (refill_line)
    );

    icache i_icache (
        .clk        (clk),
        .rst        (rst),
        .lookup_pc  (lookup_pc),
        .hit        (hit),
        .hit_inst   (hit_inst),
        .fill_valid (fill_valid),
        .fill_addr  (fill_addr),
        .fill_line  (fill_line)
    );

    refill_ctrl i_refill_ctrl (
        .clk          (clk),
        .rst          (rst),
        .refill_req   (refill_req),
        .refill_addr  (refill_addr),
        .refill_done  (refill_done),
        .refill_fault (refill_fault),
        .refill_line  (refill_line),
        .fill_valid   (fill_valid),
        .fill_addr    (fill_addr),
        .fill_line    (fill_line),
        .arvalid      (arvalid),
        .arready      (arready),
        .araddr       (araddr),
        .arid         (arid),
        .arlen        (arlen),
        .arsize       (arsize),
        .arburst      (arburst),
        .rvalid       (rvalid),
        .rready       (rready),
        .rdata        (rdata),
        .rresp        (rresp),
        .rlast        (rlast),
        .rid          (rid)
    );

endmodule

//--- verif/axi_mem_model.sv
`timescale 1ns/1ps

module axi_mem_model
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        arvalid,
    output logic        arready,
    input  logic [31:0] araddr,
    input  logic [3:0]  arid,
    input  logic [7:0]  arlen,
    input  logic [1:0]  arburst,
    output logic        rvalid,
    input  logic        rready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rlast,
    output logic [3:0]  rid
);

    localparam logic [1:0] resp_slverr = 2'b10;

    logic        busy;
    logic [31:0] addr_q;
    logic [7:0]  left_q; // beats still owed after the current one.
    logic        incr_q;

    // memory content follows the address.
    function automatic logic [31:0] word_at(input logic [31:0] addr);
        logic [31:0] x;
        x = addr ^ 32'h5A5A_0000;
        return (x << 3) | (x >> 29);
    endfunction

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rdata   <= '0;
            rresp   <= resp_okay;
            rlast   <= 1'b0;
            rid     <= '0;
            busy    <= 1'b0;
            addr_q  <= '0;
            left_q  <= '0;
            incr_q  <= 1'b0;
        end else if (!busy) begin
            if (arvalid && arready) begin
                arready <= 1'b0;
                busy    <= 1'b1;
                addr_q  <= araddr;
                left_q  <= arlen;
                incr_q  <= (arburst == burst_incr);
                rid     <= arid;
            end else begin
                arready <= ($urandom % 3) != 0; // random address stall.
            end
        end else if (rvalid && rready) begin
            rvalid <= 1'b0;
            if (left_q == 8'd0) begin
                busy <= 1'b0;
            end else begin
                left_q <= left_q - 8'd1;
                if (incr_q) addr_q <= addr_q + 32'd4;
            end
        end else if (!rvalid && ($urandom % 4) != 0) begin
            rvalid <= 1'b1;
            rdata  <= word_at(addr_q);
            rresp  <= (addr_q[31:8] == 24'h90_0000) ? resp_slverr : resp_okay; // fault window.
            rlast  <= (left_q == 8'd0);
        end
    end

endmodule

//--- verif/tb_fetch_top.sv
`timescale 1ns/1ps

module tb_fetch_top
    import fetch_pkg::*;
();

    localparam int max_cycles = 20000; // about ten times the expected run.

    logic        clk;
    logic        rst;
    logic        inst_valid;
    logic        inst_ready;
    logic [31:0] inst_pc;
    logic [31:0] inst_data;
    logic        inst_fault;
    logic        redirect_valid;
    logic [31:0] redirect_pc;
    logic        arvalid;
    logic        arready;
    logic [31:0] araddr;
    logic [3:0]  arid;
    logic [7:0]  arlen;
    logic [2:0]  arsize;
    logic [1:0]  arburst;
    logic        rvalid;
    logic        rready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rlast;
    logic [3:0]  rid;

    string       test_name;
    bit          random_ready;
    logic [31:0] exp_q[$];
    logic [41:0] ar_log[$]; // {arburst, arlen, araddr}.
    logic [31:0] pc_exp;
    logic [31:0] data_exp;
    logic        fault_exp;
    int          accepted = 0;
    int          ar_count = 0;
    int          cycles = 0;
    int          item_errors = 0;
    int          ar_errors = 0;
    int          shape_errors = 0;
    int          mark;
    int          gap;

    fetch_top i_fetch_top (.*);

    axi_mem_model i_axi_mem_model (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] expected_inst(input logic [31:0] addr);
        logic [31:0] x;
        x = addr ^ 32'h5A5A_0000;
        return {x[28:0], x[31:29]};
    endfunction

    function automatic logic in_fault_window(input logic [31:0] addr);
        return (addr >= 32'h9000_0000) && (addr <= 32'h9000_00FF);
    endfunction

    function automatic bit value_ok(input string what, input logic [31:0] exp,
                                    input logic [31:0] act);
        bit ok;
        ok = (act === exp);
        assert (ok) else $display("ERROR %s: %s expected %h actual %h", test_name, what, exp, act);
        return ok;
    endfunction

    function automatic logic [31:0] random_target();
        logic [31:0] r;
        r = $urandom;
        case (r[1:0])
            2'd0:    return 32'h8000_0000 | (r & 32'h0000_03FC);
            2'd1:    return 32'hA000_0000 | (r & 32'h0000_03FC);
            2'd2:    return 32'h9000_0000 | (r & 32'h0000_00FC); // fault window.
            default: return 32'hB000_0000 | (r & 32'h0000_03FC);
        endcase
    endfunction

    task automatic redirect_to(input logic [31:0] target);
        @(posedge clk);
        redirect_valid <= 1'b1;
        redirect_pc    <= target;
        @(posedge clk);
        redirect_valid <= 1'b0;
    endtask

    task automatic wait_items(input int n);
        int target;
        target = accepted + n;
        while (accepted < target) begin
            @(posedge clk);
            if (random_ready) inst_ready <= ($urandom % 100) < 40;
        end
    endtask

    // ARs logged since from that fall into the line at base.
    task automatic check_line_ars(input logic [31:0] base, input int from, input int ars,
                                  input logic [7:0] len, input logic [1:0] burst);
        int          seen;
        int          i;
        logic [41:0] entry;
        seen = 0;
        for (i = from; i < ar_count; i++) begin
            entry = ar_log[i];
            if (entry[31:offset_bits] == base[31:offset_bits]) begin
                if (!value_ok("araddr", base + 32'(4 * seen), entry[31:0])) shape_errors++;
                if (!value_ok("arlen", 32'(len), 32'(entry[39:32]))) shape_errors++;
                if (!value_ok("arburst", 32'(burst), 32'(entry[41:40]))) shape_errors++;
                seen++;
            end
        end
        if (!value_ok("ar count", 32'(ars), 32'(seen))) shape_errors++;
    endtask

    always @(posedge clk) begin
        if (!rst && arvalid && arready) begin
            ar_log.push_back({arburst, arlen, araddr});
            ar_count <= ar_count + 1;
            if (!value_ok("arsize", 32'(size_word), 32'(arsize))) ar_errors++;
            if (!value_ok("arid", 32'd0, 32'(arid))) ar_errors++;
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            exp_q.delete();
            exp_q.push_back(reset_pc);
        end else begin
            if (inst_valid && inst_ready) begin
                pc_exp    = exp_q.pop_front();
                fault_exp = in_fault_window(pc_exp);
                data_exp  = fault_exp ? 32'd0 : expected_inst(pc_exp);
                if (!value_ok("inst_pc", pc_exp, inst_pc)) item_errors++;
                if (!value_ok("inst_data", data_exp, inst_data)) item_errors++;
                if (!value_ok("inst_fault", 32'(fault_exp), 32'(inst_fault))) item_errors++;
                exp_q.push_back(pc_exp + 32'd4);
                accepted <= accepted + 1;
            end
            if (redirect_valid) begin // stream restarts at the target.
                exp_q.delete();
                exp_q.push_back(redirect_pc);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("timeout: no verdict after %0d cycles", cycles);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(3));
        test_name      = "reset";
        random_ready   = 1'b0;
        rst            = 1'b1;
        inst_ready     = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        repeat (5) @(posedge clk);
        // handshake outputs idle while in reset.
        if (!value_ok("inst_valid", 32'd0, 32'(inst_valid))) item_errors++;
        if (!value_ok("arvalid", 32'd0, 32'(arvalid))) ar_errors++;
        if (!value_ok("rready", 32'd0, 32'(rready))) ar_errors++;
        rst <= 1'b0;

        test_name = "sequential_fetch";
        inst_ready <= 1'b1;
        wait_items(40);

        // lines 4 to 7 are still cached.
        test_name = "cache_hits";
        inst_ready <= 1'b0;
        redirect_to(reset_pc + 32'h40);
        inst_ready <= 1'b1;
        wait_items(1);
        mark = ar_count;
        wait_items(15);
        if (!value_ok("ar count", 32'(mark), 32'(ar_count))) shape_errors++;

        test_name = "burst_refill";
        inst_ready <= 1'b0;
        mark = ar_count;
        redirect_to(32'hA000_0000);
        inst_ready <= 1'b1;
        wait_items(4);
        check_line_ars(32'hA000_0000, mark, 1, 8'(line_words - 1), burst_incr);

        test_name = "single_refill";
        inst_ready <= 1'b0;
        mark = ar_count;
        redirect_to(32'h8000_1000);
        inst_ready <= 1'b1;
        wait_items(4);
        check_line_ars(32'h8000_1000, mark, line_words, 8'd0, burst_fixed);

        test_name = "access_fault";
        inst_ready <= 1'b0;
        redirect_to(32'h9000_0000);
        inst_ready <= 1'b1;
        wait_items(4);
        inst_ready <= 1'b0;
        mark = ar_count;
        redirect_to(32'h9000_0000); // faulted line must be fetched again.
        inst_ready <= 1'b1;
        wait_items(1);
        check_line_ars(32'h9000_0000, mark, line_words, 8'd0, burst_fixed);

        test_name = "backpressure";
        random_ready = 1'b1;
        redirect_to(32'hA000_0200);
        wait_items(60);
        random_ready = 1'b0;

        test_name = "random_redirect";
        inst_ready <= 1'b1;
        repeat (16) begin
            gap = $urandom % 20;
            repeat (gap) @(posedge clk);
            redirect_to(random_target());
            if ($urandom % 2 == 0) wait_items(2); // otherwise next redirect may hit a miss.
        end
        wait_items(4);

        test_name = "summary";
        $display("errors: %0d item, %0d ar field, %0d refill shape; %0d items accepted",
                 item_errors, ar_errors, shape_errors, accepted);
        if (item_errors + ar_errors + shape_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- files.f
verilog/fetch_pkg.sv
verilog/icache.sv
verilog/refill_ctrl.sv
verilog/fetch_unit.sv
verilog/fetch_top.sv
verif/axi_mem_model.sv
verif/tb_fetch_top.sv

//--- run.sh
#!/bin/sh
# build with verilator, run, then look for the pass line in the log.
rm -rf obj_dir sim.log build.log
verilator --binary --assert --top-module tb_fetch_top -f files.f -o sim > build.log 2>&1 &&
    ./obj_dir/sim > sim.log 2>&1
grep -qx "Test passed" sim.log && echo "PASS" || { echo "FAIL, see build.log and sim.log"; exit 1; }
